//--- verilog/shade_pkg.sv
package shade_pkg;

        // widths of the shading datapath
        localparam int COLOR_W = 7;
        localparam int WEIGHT_W = 8;
        localparam int PROD_W = WEIGHT_W + COLOR_W;   // one 8x7 product
        localparam int SUM_W = PROD_W + 2;            // three products never overflow this
        localparam int TAG_W = 4;

        // the weights add up to 255, so bits 14 to 8 scale the sum back to a colour
        localparam int RESULT_LSB = 8;
        localparam logic [WEIGHT_W-1:0] WEIGHT_FULL = 8'd255;

        // flow control
        localparam int SHADE_CREDITS = 8;             // result FIFO depth and upstream credits
        localparam int OUT_CREDITS = 4;               // downstream credits after reset

        localparam int FIFO_PTR_W = $clog2(SHADE_CREDITS);
        localparam int FIFO_CNT_W = $clog2(SHADE_CREDITS + 1);
        localparam int CREDIT_CNT_W = $clog2(OUT_CREDITS + 1);

        // hit candidate selector, codes 011 and 111 are invalid
        typedef enum logic [2:0]
        {
                HIT_01A = 3'b000,
                HIT_01B = 3'b001,
                HIT_01C = 3'b010,
                HIT_10A = 3'b100,
                HIT_10B = 3'b101,
                HIT_10C = 3'b110
        } hit_sel_e;

endpackage

//--- verilog/shade_decode.sv
`timescale 1ns/1ps

module shade_decode import shade_pkg::*;
(
        input  logic                clk,
        input  logic                reset,
        input  logic                in_valid,
        input  logic [TAG_W-1:0]    in_tag,
        input  hit_sel_e            sel,
        input  logic [WEIGHT_W-1:0] u01a, u01b, u01c,
        input  logic [WEIGHT_W-1:0] v01a, v01b, v01c,
        input  logic [WEIGHT_W-1:0] u10a, u10b, u10c,
        input  logic [WEIGHT_W-1:0] v10a, v10b, v10c,
        input  logic [COLOR_W-1:0]  ru, rv, rw,
        input  logic [COLOR_W-1:0]  gu, gv, gw,
        input  logic [COLOR_W-1:0]  bu, bv, bw,
        output logic                d_valid,
        output logic [TAG_W-1:0]    d_tag,
        output logic [WEIGHT_W-1:0] u_w,
        output logic [WEIGHT_W-1:0] v_w,
        output logic [WEIGHT_W-1:0] w_w,
        output logic [COLOR_W-1:0]  d_ru, d_rv, d_rw,
        output logic [COLOR_W-1:0]  d_gu, d_gv, d_gw,
        output logic [COLOR_W-1:0]  d_bu, d_bv, d_bw
);

        logic [WEIGHT_W-1:0] u_sel;
        logic [WEIGHT_W-1:0] v_sel;
        logic [WEIGHT_W-1:0] w_sel;

        always_comb
        begin
                case (sel)
                        HIT_01A:
                        begin
                                u_sel = u01a;
                                v_sel = v01a;
                        end
                        HIT_01B:
                        begin
                                u_sel = u01b;
                                v_sel = v01b;
                        end
                        HIT_01C:
                        begin
                                u_sel = u01c;
                                v_sel = v01c;
                        end
                        HIT_10A:
                        begin
                                u_sel = u10a;
                                v_sel = v10a;
                        end
                        HIT_10B:
                        begin
                                u_sel = u10b;
                                v_sel = v10b;
                        end
                        HIT_10C:
                        begin
                                u_sel = u10c;
                                v_sel = v10c;
                        end
                        default:
                        begin
                                u_sel = '0;         // invalid code leaves all weight on w
                                v_sel = '0;
                        end
                endcase
        end

        assign w_sel = WEIGHT_FULL - u_sel - v_sel;  // wraps modulo 256 when u + v > 255

        always_ff @(posedge clk)
        begin
                if (reset)
                        d_valid <= 1'b0;
                else
                        d_valid <= in_valid;
        end

        always_ff @(posedge clk)
        begin
                d_tag <= in_tag;
                u_w <= u_sel;
                v_w <= v_sel;
                w_w <= w_sel;
                d_ru <= ru;
                d_rv <= rv;
                d_rw <= rw;
                d_gu <= gu;
                d_gv <= gv;
                d_gw <= gw;
                d_bu <= bu;
                d_bv <= bv;
                d_bw <= bw;
        end

endmodule

//--- verilog/shade_execute.sv
`timescale 1ns/1ps

module shade_execute import shade_pkg::*;
(
        input  logic                clk,
        input  logic                reset,
        input  logic                d_valid,
        input  logic [TAG_W-1:0]    d_tag,
        input  logic [WEIGHT_W-1:0] u_w,
        input  logic [WEIGHT_W-1:0] v_w,
        input  logic [WEIGHT_W-1:0] w_w,
        input  logic [COLOR_W-1:0]  d_ru, d_rv, d_rw,
        input  logic [COLOR_W-1:0]  d_gu, d_gv, d_gw,
        input  logic [COLOR_W-1:0]  d_bu, d_bv, d_bw,
        output logic                e_valid,
        output logic [TAG_W-1:0]    e_tag,
        output logic [SUM_W-1:0]    r_sum,
        output logic [SUM_W-1:0]    g_sum,
        output logic [SUM_W-1:0]    b_sum
);

        logic               p_valid;                 // products are held in stage one
        logic [TAG_W-1:0]   p_tag;

        logic [PROD_W-1:0]  prod_ru;
        logic [PROD_W-1:0]  prod_rv;
        logic [PROD_W-1:0]  prod_rw;
        logic [PROD_W-1:0]  prod_gu;
        logic [PROD_W-1:0]  prod_gv;
        logic [PROD_W-1:0]  prod_gw;
        logic [PROD_W-1:0]  prod_bu;
        logic [PROD_W-1:0]  prod_bv;
        logic [PROD_W-1:0]  prod_bw;

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        p_valid <= 1'b0;
                        e_valid <= 1'b0;
                end
                else
                begin
                        p_valid <= d_valid;
                        e_valid <= p_valid;
                end
        end

        // stage one, nine 8x7 multiplies
        always_ff @(posedge clk)
        begin
                p_tag <= d_tag;
                prod_ru <= u_w * d_ru;
                prod_rv <= v_w * d_rv;
                prod_rw <= w_w * d_rw;
                prod_gu <= u_w * d_gu;
                prod_gv <= v_w * d_gv;
                prod_gw <= w_w * d_gw;
                prod_bu <= u_w * d_bu;
                prod_bv <= v_w * d_bv;
                prod_bw <= w_w * d_bw;
        end

        // stage two, sums are sized so the carry out of the products is kept
        always_ff @(posedge clk)
        begin
                e_tag <= p_tag;
                r_sum <= SUM_W'(prod_ru) + SUM_W'(prod_rv) + SUM_W'(prod_rw);
                g_sum <= SUM_W'(prod_gu) + SUM_W'(prod_gv) + SUM_W'(prod_gw);
                b_sum <= SUM_W'(prod_bu) + SUM_W'(prod_bv) + SUM_W'(prod_bw);
        end

endmodule

//--- verilog/shade_result.sv
`timescale 1ns/1ps

module shade_result import shade_pkg::*;
(
        input  logic               clk,
        input  logic               reset,
        input  logic               e_valid,
        input  logic [TAG_W-1:0]   e_tag,
        input  logic [SUM_W-1:0]   r_sum,
        input  logic [SUM_W-1:0]   g_sum,
        input  logic [SUM_W-1:0]   b_sum,
        input  logic               out_credit,
        output logic               out_valid,
        output logic [TAG_W-1:0]   out_tag,
        output logic [COLOR_W-1:0] r,
        output logic [COLOR_W-1:0] g,
        output logic [COLOR_W-1:0] b,
        output logic               in_credit
);

        logic [TAG_W-1:0]        tag_mem [SHADE_CREDITS];
        logic [COLOR_W-1:0]      r_mem [SHADE_CREDITS];
        logic [COLOR_W-1:0]      g_mem [SHADE_CREDITS];
        logic [COLOR_W-1:0]      b_mem [SHADE_CREDITS];

        logic [FIFO_PTR_W-1:0]   wr_ptr;
        logic [FIFO_PTR_W-1:0]   rd_ptr;
        logic [FIFO_CNT_W-1:0]   fifo_count;
        logic [CREDIT_CNT_W-1:0] credit_count;     // downstream credits still held
        logic                    pop;

        // an entry leaves only if it was already stored before this edge
        assign pop = (fifo_count != '0) && (credit_count != '0);

        always_ff @(posedge clk)
        begin
                if (e_valid)
                begin
                        tag_mem[wr_ptr] <= e_tag;
                        r_mem[wr_ptr] <= r_sum[RESULT_LSB +: COLOR_W];
                        g_mem[wr_ptr] <= g_sum[RESULT_LSB +: COLOR_W];
                        b_mem[wr_ptr] <= b_sum[RESULT_LSB +: COLOR_W];
                end
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end
                else
                begin
                        if (e_valid)
                                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
                        if (pop)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                        fifo_count <= '0;
                else
                begin
                        case ({e_valid, pop})
                                2'b10:   fifo_count <= fifo_count + 1'b1;
                                2'b01:   fifo_count <= fifo_count - 1'b1;
                                default: fifo_count <= fifo_count;
                        endcase
                end
        end

        // a returned credit and a spent one in the same cycle cancel out
        always_ff @(posedge clk)
        begin
                if (reset)
                        credit_count <= CREDIT_CNT_W'(OUT_CREDITS);
                else
                begin
                        case ({out_credit, pop})
                                2'b10:   credit_count <= credit_count + 1'b1;
                                2'b01:   credit_count <= credit_count - 1'b1;
                                default: credit_count <= credit_count;
                        endcase
                end
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        out_valid <= 1'b0;
                        in_credit <= 1'b0;
                end
                else
                begin
                        out_valid <= pop;
                        in_credit <= pop;          // the freed slot goes back upstream
                end
        end

        always_ff @(posedge clk)
        begin
                if (pop)
                begin
                        out_tag <= tag_mem[rd_ptr];
                        r <= r_mem[rd_ptr];
                        g <= g_mem[rd_ptr];
                        b <= b_mem[rd_ptr];
                end
        end

endmodule

//--- verilog/shade_top.sv
`timescale 1ns/1ps

module shade_top import shade_pkg::*;
(
        input  logic                clk,
        input  logic                reset,
        input  logic                in_valid,
        input  logic [TAG_W-1:0]    in_tag,
        input  hit_sel_e            sel,
        input  logic [WEIGHT_W-1:0] u01a, u01b, u01c,
        input  logic [WEIGHT_W-1:0] v01a, v01b, v01c,
        input  logic [WEIGHT_W-1:0] u10a, u10b, u10c,
        input  logic [WEIGHT_W-1:0] v10a, v10b, v10c,
        input  logic [COLOR_W-1:0]  ru, rv, rw,
        input  logic [COLOR_W-1:0]  gu, gv, gw,
        input  logic [COLOR_W-1:0]  bu, bv, bw,
        output logic                in_credit,
        output logic                out_valid,
        output logic [TAG_W-1:0]    out_tag,
        output logic [COLOR_W-1:0]  r,
        output logic [COLOR_W-1:0]  g,
        output logic [COLOR_W-1:0]  b,
        input  logic                out_credit
);

        // decode to execute
        logic                d_valid;
        logic [TAG_W-1:0]    d_tag;
        logic [WEIGHT_W-1:0] u_w;
        logic [WEIGHT_W-1:0] v_w;
        logic [WEIGHT_W-1:0] w_w;
        logic [COLOR_W-1:0]  d_ru, d_rv, d_rw;
        logic [COLOR_W-1:0]  d_gu, d_gv, d_gw;
        logic [COLOR_W-1:0]  d_bu, d_bv, d_bw;

        // execute to result
        logic                e_valid;
        logic [TAG_W-1:0]    e_tag;
        logic [SUM_W-1:0]    r_sum;
        logic [SUM_W-1:0]    g_sum;
        logic [SUM_W-1:0]    b_sum;

        shade_decode shade_decode_inst
        (
                .clk      (clk),
                .reset    (reset),
                .in_valid (in_valid),
                .in_tag   (in_tag),
                .sel      (sel),
                .u01a (u01a), .u01b (u01b), .u01c (u01c),
                .v01a (v01a), .v01b (v01b), .v01c (v01c),
                .u10a (u10a), .u10b (u10b), .u10c (u10c),
                .v10a (v10a), .v10b (v10b), .v10c (v10c),
                .ru (ru), .rv (rv), .rw (rw),
                .gu (gu), .gv (gv), .gw (gw),
                .bu (bu), .bv (bv), .bw (bw),
                .d_valid  (d_valid),
                .d_tag    (d_tag),
                .u_w      (u_w),
                .v_w      (v_w),
                .w_w      (w_w),
                .d_ru (d_ru), .d_rv (d_rv), .d_rw (d_rw),
                .d_gu (d_gu), .d_gv (d_gv), .d_gw (d_gw),
                .d_bu (d_bu), .d_bv (d_bv), .d_bw (d_bw)
        );

        shade_execute shade_execute_inst
        (
                .clk      (clk),
                .reset    (reset),
                .d_valid  (d_valid),
                .d_tag    (d_tag),
                .u_w      (u_w),
                .v_w      (v_w),
                .w_w      (w_w),
                .d_ru (d_ru), .d_rv (d_rv), .d_rw (d_rw),
                .d_gu (d_gu), .d_gv (d_gv), .d_gw (d_gw),
                .d_bu (d_bu), .d_bv (d_bv), .d_bw (d_bw),
                .e_valid  (e_valid),
                .e_tag    (e_tag),
                .r_sum    (r_sum),
                .g_sum    (g_sum),
                .b_sum    (b_sum)
        );

        shade_result shade_result_inst
        (
                .clk        (clk),
                .reset      (reset),
                .e_valid    (e_valid),
                .e_tag      (e_tag),
                .r_sum      (r_sum),
                .g_sum      (g_sum),
                .b_sum      (b_sum),
                .out_credit (out_credit),
                .out_valid  (out_valid),
                .out_tag    (out_tag),
                .r          (r),
                .g          (g),
                .b          (b),
                .in_credit  (in_credit)
        );

endmodule

//--- tests/shade_chk.sv
`timescale 1ns/1ps

module shade_chk import shade_pkg::*;
(
        input  logic                    clk,
        input  logic                    reset,
        input  logic [FIFO_CNT_W-1:0]   fifo_count,
        input  logic                    out_credit,
        input  logic                    out_valid,
        input  logic                    in_credit
);

        logic [CREDIT_CNT_W-1:0] credits_held;        // downstream credits as the consumer counts them

        always_ff @(posedge clk)
        begin
                if (reset)
                        credits_held <= CREDIT_CNT_W'(OUT_CREDITS);
                else
                        credits_held <= credits_held + out_credit - out_valid;
        end

        // one FIFO slot per upstream credit
        fifo_bound: assert property (@(posedge clk) disable iff (reset)
                fifo_count <= SHADE_CREDITS)
                else $error("result FIFO holds %0d entries", fifo_count);

        // every item that leaves must be covered by a credit the consumer granted
        credit_spent: assert property (@(posedge clk) disable iff (reset)
                out_valid |-> credits_held != '0)
                else $error("out_valid raised with no downstream credit");

        credit_return: assert property (@(posedge clk) disable iff (reset)
                in_credit == out_valid)
                else $error("in_credit and out_valid differ");

endmodule

bind shade_result shade_chk shade_chk_inst
(
        .clk          (clk),
        .reset        (reset),
        .fifo_count   (fifo_count),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .in_credit    (in_credit)
);

//--- tests/shade_tb.sv
`timescale 1ns/1ps

module shade_tb
        import shade_pkg::*;
();

        localparam int PERIOD = 100;
        localparam int REPS_VALID = 8;                // per valid selector
        localparam int REPS_INVALID = 8;              // per invalid selector
        localparam int REPS_WRAP = 16;
        localparam int BP_REQS = 10;
        localparam int STREAM_REQS = 50;
        localparam int TOTAL_REQS = 6 * REPS_VALID + 2 * REPS_INVALID + REPS_WRAP + BP_REQS
                + 1 + STREAM_REQS;
        localparam int WATCHDOG_CYCLES = 200 * TOTAL_REQS + 2000;

        logic                         clk;
        logic                         reset;
        logic                         in_valid;
        logic [TAG_W-1:0]             in_tag;
        hit_sel_e                     sel;
        logic [5:0][WEIGHT_W-1:0]     u_in;           // candidates in order 01a 01b 01c 10a 10b 10c
        logic [5:0][WEIGHT_W-1:0]     v_in;
        logic [8:0][COLOR_W-1:0]      col;            // ru rv rw gu gv gw bu bv bw
        logic                         out_credit;
        logic                         in_credit;
        logic                         out_valid;
        logic [TAG_W-1:0]             out_tag;
        logic [COLOR_W-1:0]           r;
        logic [COLOR_W-1:0]           g;
        logic [COLOR_W-1:0]           b;

        logic [TAG_W+3*COLOR_W-1:0]   exp_q [$];      // tag and colours in send order
        logic [TAG_W+3*COLOR_W-1:0]   head;
        logic [TAG_W-1:0]             tag_next;
        int errors = 0;
        int checks = 0;
        int tests_done = 0;
        int test_err_base = 0;
        int credits = SHADE_CREDITS;                  // sender's upstream credits
        int sent = 0;
        int credit_pulses = 0;
        int outputs_seen = 0;
        int owed = 0;                                 // credits the consumer still has to return
        int cycle = 0;
        int last_send_cycle = 0;
        int last_out_cycle = 0;
        int return_mode = 1;                          // 0 withhold, 1 random, 2 every cycle
        int base;

        shade_top shade_top_inst
        (
                .clk (clk), .reset (reset), .in_valid (in_valid), .in_tag (in_tag), .sel (sel),
                .u01a (u_in[0]), .u01b (u_in[1]), .u01c (u_in[2]),
                .v01a (v_in[0]), .v01b (v_in[1]), .v01c (v_in[2]),
                .u10a (u_in[3]), .u10b (u_in[4]), .u10c (u_in[5]),
                .v10a (v_in[3]), .v10b (v_in[4]), .v10c (v_in[5]),
                .ru (col[0]), .rv (col[1]), .rw (col[2]),
                .gu (col[3]), .gv (col[4]), .gw (col[5]),
                .bu (col[6]), .bv (col[7]), .bw (col[8]),
                .in_credit (in_credit), .out_valid (out_valid), .out_tag (out_tag),
                .r (r), .g (g), .b (b), .out_credit (out_credit)
        );

        always #(PERIOD / 2) clk = ~clk;

        task automatic check_value(input string name, input logic [31:0] actual,
                input logic [31:0] expected);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name,
                                actual, expected);
                end
        endtask

        // blend of the three vertex colours, result is bits 14 to 8 of each channel sum
        function automatic logic [3*COLOR_W-1:0] expected_color(input logic [2:0] code,
                input logic [5:0][WEIGHT_W-1:0] u_all, input logic [5:0][WEIGHT_W-1:0] v_all,
                input logic [8:0][COLOR_W-1:0] cols);
                int idx;
                int u;
                int v;
                int w;
                int sum;
                logic [3*COLOR_W-1:0] rgb;
                case (code)
                        3'b000:  idx = 0;
                        3'b001:  idx = 1;
                        3'b010:  idx = 2;
                        3'b100:  idx = 3;
                        3'b101:  idx = 4;
                        3'b110:  idx = 5;
                        default: idx = -1;            // invalid code puts all weight on w
                endcase
                u = (idx < 0) ? 0 : int'(u_all[idx]);
                v = (idx < 0) ? 0 : int'(v_all[idx]);
                w = (255 - u - v + 512) % 256;        // wraps modulo 256
                for (int ch = 0; ch < 3; ch++)
                begin
                        sum = u * cols[3 * ch] + v * cols[3 * ch + 1] + w * cols[3 * ch + 2];
                        rgb[3 * COLOR_W - 1 - COLOR_W * ch -: COLOR_W] = COLOR_W'((sum >> 8) % 128);
                end
                return rgb;
        endfunction

        function automatic logic [2:0] pick_code(input int unsigned n);
                case (n % 6)
                        0:       return 3'b000;
                        1:       return 3'b001;
                        2:       return 3'b010;
                        3:       return 3'b100;
                        4:       return 3'b101;
                        default: return 3'b110;
                endcase
        endfunction

        task automatic load_weights(input bit wrap);
                int u;
                for (int i = 0; i < 6; i++)
                begin
                        if (wrap)
                        begin
                                u = 128 + $urandom % 128;
                                v_in[i] = WEIGHT_W'(256 - u + $urandom % u);   // u + v above 255
                        end
                        else
                        begin
                                u = $urandom % 256;
                                v_in[i] = WEIGHT_W'($urandom % (256 - u));
                        end
                        u_in[i] = WEIGHT_W'(u);
                end
                for (int i = 0; i < 9; i++)
                        col[i] = COLOR_W'($urandom % 128);
        endtask

        // called on a falling edge, returns on the next one with in_valid low
        task automatic send_request(input logic [2:0] code);
                while (credits == 0)
                        @(negedge clk);
                in_valid = 1'b1;
                in_tag = tag_next;
                sel = hit_sel_e'(code);
                exp_q.push_back({tag_next, expected_color(code, u_in, v_in, col)});
                credits--;
                sent++;
                tag_next++;
                last_send_cycle = cycle + 1;
                if (sent - outputs_seen > SHADE_CREDITS)
                begin
                        errors++;
                        $display("more than %0d requests outstanding at %0t", SHADE_CREDITS, $time);
                end
                @(negedge clk);
                in_valid = 1'b0;
        endtask

        task automatic wait_drain;
                while (exp_q.size() != 0)
                        @(negedge clk);
                repeat (2) @(negedge clk);
        endtask

        task automatic finish_test(input string name);
                tests_done++;
                $display("%s: %0d errors", name, errors - test_err_base);
                test_err_base = errors;
        endtask

        // comparator and credit bookkeeping, registered outputs seen just before each edge
        always @(posedge clk)
        begin
                cycle = cycle + 1;
                if (!reset && in_credit)
                begin
                        if (credits >= SHADE_CREDITS)
                        begin
                                errors++;
                                $display("in_credit returned with nothing outstanding at %0t", $time);
                        end
                        credits++;
                        credit_pulses++;
                end
                if (!reset && out_credit)
                        owed--;
                if (!reset && out_valid)
                begin
                        outputs_seen++;
                        owed++;
                        last_out_cycle = cycle - 1;
                        if (exp_q.size() == 0)
                        begin
                                errors++;
                                $display("out_valid at %0t with no request outstanding", $time);
                        end
                        else
                        begin
                                head = exp_q.pop_front();
                                check_value("out_tag", out_tag, head[3*COLOR_W +: TAG_W]);
                                check_value("r", r, head[2*COLOR_W +: COLOR_W]);
                                check_value("g", g, head[COLOR_W +: COLOR_W]);
                                check_value("b", b, head[0 +: COLOR_W]);
                        end
                end
        end

        // downstream consumer, only hands back credits it has spent
        always @(negedge clk)
        begin
                if (reset || owed == 0 || return_mode == 0)
                        out_credit = 1'b0;
                else if (return_mode == 2)
                        out_credit = 1'b1;
                else
                        out_credit = 1'($urandom % 2);
        end

        initial
        begin
                #(WATCHDOG_CYCLES * PERIOD);
                $display("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
                $display("TEST FAILED");
                $finish;
        end

        initial
        begin
                void'($urandom(32'h2d1980df));
                clk = 1'b0;
                reset = 1'b1;
                in_valid = 1'b0;
                in_tag = '0;
                sel = HIT_01A;
                u_in = '0;
                v_in = '0;
                col = '0;
                out_credit = 1'b0;
                tag_next = '0;
                for (int i = 0; i < 6; i++)
                begin
                        @(negedge clk);
                        if (i == 2)
                                reset = 1'b0;         // held for 3 cycles
                        check_value("out_valid", out_valid, 0);
                        check_value("in_credit", in_credit, 0);
                end
                finish_test("quiet after reset");

                for (int s = 0; s < 6; s++)
                begin
                        repeat (REPS_VALID)
                        begin
                                load_weights(1'b0);
                                send_request(pick_code(s));
                        end
                end
                wait_drain;
                finish_test("valid selectors");

                repeat (REPS_INVALID)
                begin
                        load_weights(1'b0);
                        send_request(3'b011);
                        load_weights(1'b0);
                        send_request(3'b111);
                end
                wait_drain;
                finish_test("invalid selectors");

                for (int i = 0; i < REPS_WRAP; i++)
                begin
                        load_weights(1'b1);
                        send_request(pick_code(i));
                end
                wait_drain;
                finish_test("wrapped w");

                return_mode = 2;
                while (owed != 0)
                        @(negedge clk);
                return_mode = 0;
                base = outputs_seen;
                repeat (BP_REQS)
                begin
                        load_weights(1'b0);
                        send_request(pick_code($urandom));
                end
                repeat (30) @(negedge clk);
                check_value("outputs while credits withheld", outputs_seen - base, OUT_CREDITS);
                check_value("out_valid while credits withheld", out_valid, 0);
                return_mode = 2;
                wait_drain;
                check_value("outputs after credits return", outputs_seen - base, BP_REQS);
                finish_test("back-pressure");

                while (owed != 0)
                        @(negedge clk);
                load_weights(1'b0);
                send_request(pick_code($urandom));
                wait_drain;
                check_value("latency", last_out_cycle - last_send_cycle, 4);
                repeat (STREAM_REQS)
                begin
                        load_weights(1'b0);
                        send_request(pick_code($urandom));
                end
                wait_drain;
                finish_test("streaming");

                check_value("in_credit pulses", credit_pulses, sent);
                check_value("sender credits", credits, SHADE_CREDITS);
                finish_test("credit accounting");

                $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
                if (errors == 0)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

//--- sources.f
verilog/shade_pkg.sv
verilog/shade_decode.sv
verilog/shade_execute.sv
verilog/shade_result.sv
verilog/shade_top.sv
tests/shade_chk.sv
tests/shade_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module shade_tb \
        -f sources.f -o shade_sim \
        && ./obj_dir/shade_sim > sim.log 2>&1 \
        || echo "TEST FAILED: build or simulation error" >> sim.log

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
